//--- axi_addr_remap.f
+incdir+include
src/remap_pkg.sv
src/remap_rule_decode.sv
src/remap_addr_xlate.sv
src/axi_modify_address.sv
src/remap_write_steer.sv
src/remap_read_steer.sv
src/axi_addr_remap.sv
sim/tb_axi_addr_remap.sv

//--- Bender.yml
package:
  name: axi_addr_remap

export_include_dirs:
  - include

sources:
  - files:
      - src/remap_pkg.sv
      - src/remap_rule_decode.sv
      - src/remap_addr_xlate.sv
      - src/axi_modify_address.sv
      - src/remap_write_steer.sv
      - src/remap_read_steer.sv
      - src/axi_addr_remap.sv
  - target: test
    files:
      - sim/tb_axi_addr_remap.sv

//--- sim/tb_axi_addr_remap.sv
// ##########################################################
// random AXI traffic through the remapper, checked against a
// first-match model, with a memory responder on the master port
// ##########################################################
`timescale 1ns/1ps
`include "remap_cfg.svh"

module tb_axi_addr_remap;

  localparam int          NUM_TXN        = 200;
  localparam int          TIMEOUT_CYCLES = NUM_TXN * 40;
  localparam logic [31:0] SEED           = 32'he69b32d2;

  logic                   clk_i;
  logic                   reset_i;
  remap_pkg::remap_rule_t rules [`REMAP_NUM_RULES];
  remap_pkg::slv_req_t    slv_req  = '0;
  remap_pkg::resp_t       slv_resp_o;
  remap_pkg::mst_req_t    mst_req_o;
  remap_pkg::resp_t       mst_resp = '0;

  logic [31:0] drv_seed  = SEED;
  logic [31:0] rsp_seed  = SEED ^ 32'h5a5a_a5a5; // separate stream for the responder
  int          cycle_cnt = 0;

  // master-side responder state
  logic                 rsp_wr_busy = 1'b0;
  logic                 rsp_b_pend  = 1'b0;
  logic                 rsp_rd_busy = 1'b0;
  remap_pkg::mst_addr_t rsp_rd_addr;
  remap_pkg::len_t      rsp_rd_len;
  remap_pkg::len_t      rsp_rd_beat;

  remap_pkg::remap_xlate_t  mon_aw, mon_ar, mon_w;
  remap_pkg::mst_aw_chan_t  exp_aw;
  remap_pkg::mst_ar_chan_t  exp_ar;

  axi_addr_remap i_axi_addr_remap (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .rules_i    ( rules      ),
    .slv_req_i  ( slv_req    ),
    .slv_resp_o ( slv_resp_o ),
    .mst_req_o  ( mst_req_o  ),
    .mst_resp_i ( mst_resp   )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_random();
    drv_seed = lcg_step(drv_seed);
    return drv_seed;
  endfunction

  function automatic logic random_ready(); // high about 3 cycles in 4
    logic [31:0] r;
    r = next_random();
    return r[31:30] != 2'b00;
  endfunction

  // first matching rule, lowest index wins
  function automatic remap_pkg::remap_xlate_t model_xlate(input remap_pkg::slv_addr_t addr);
    remap_pkg::remap_xlate_t res;
    logic                    found;
    res.addr = '0;
    res.err  = 1'b1;
    found    = 1'b0;
    for (int i = 0; i < `REMAP_NUM_RULES; i++) begin
      if (!found && addr >= rules[i].start_addr && addr < rules[i].end_addr) begin
        found = 1'b1;
        if (rules[i].op == remap_pkg::REMAP_IDENTITY) begin
          res.addr = {{(`REMAP_MST_ADDR_W-`REMAP_SLV_ADDR_W){1'b0}}, addr};
          res.err  = 1'b0;
        end else if (rules[i].op == remap_pkg::REMAP_OFFSET) begin
          res.addr = rules[i].target_addr +
                     {{(`REMAP_MST_ADDR_W-`REMAP_SLV_ADDR_W){1'b0}}, addr - rules[i].start_addr};
          res.err  = 1'b0;
        end
      end
    end
    return res;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_mst_addr(input string name, input remap_pkg::mst_addr_t got,
                                input remap_pkg::mst_addr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_aw_chan(input string name, input remap_pkg::mst_aw_chan_t got,
                               input remap_pkg::mst_aw_chan_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_ar_chan(input string name, input remap_pkg::mst_ar_chan_t got,
                               input remap_pkg::mst_ar_chan_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_w(input string name, input remap_pkg::w_chan_t got,
                         input remap_pkg::w_chan_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_b(input string name, input remap_pkg::b_chan_t got,
                         input remap_pkg::b_chan_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_r(input string name, input remap_pkg::r_chan_t got,
                         input remap_pkg::r_chan_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // four chained windows, each may overlap the one before
  task automatic build_rules();
    logic [31:0] base, size, r;
    int          deny_idx, ident_idx;
    r         = next_random();
    deny_idx  = r % 4;
    r         = next_random();
    ident_idx = (deny_idx + 1 + r % 3) % 4;
    base      = 32'h1000_0000 + (next_random() & 32'h0fff_f000);
    for (int i = 0; i < `REMAP_NUM_RULES; i++) begin
      size = 32'h0001_0000 + (next_random() & 32'h000f_f000);
      r    = next_random();
      if (i == deny_idx) rules[i].op = remap_pkg::REMAP_DENY;
      else if (i == ident_idx) rules[i].op = remap_pkg::REMAP_IDENTITY;
      else rules[i].op = remap_pkg::REMAP_OFFSET;
      rules[i].start_addr  = base;
      rules[i].end_addr    = base + size;
      rules[i].target_addr = {r[7:0], next_random() & 32'hffff_f000};
      base = base + (size >> 1) + (r[8] ? size : 32'h0);
    end
  endtask

  // inside a window most of the time, else anywhere
  function automatic remap_pkg::slv_addr_t pick_addr();
    logic [31:0] r;
    int          idx;
    r   = next_random();
    idx = r[9:8];
    if (r[2:0] < 3'd6) begin
      return rules[idx].start_addr +
             ((next_random() % (rules[idx].end_addr - rules[idx].start_addr)) & ~32'h3);
    end
    return next_random() & ~32'h3;
  endfunction

  task automatic run_write(input remap_pkg::id_t txn_id, input remap_pkg::slv_addr_t addr,
                           input remap_pkg::len_t len);
    remap_pkg::remap_xlate_t exp;
    remap_pkg::b_chan_t      exp_b;
    logic [31:0]             r;
    int                      beat;
    logic                    done;
    exp        = model_xlate(addr);
    exp_b.id   = txn_id;
    exp_b.resp = exp.err ? remap_pkg::RESP_DECERR : remap_pkg::RESP_OKAY;
    slv_req.aw       <= '{id: txn_id, addr: addr, len: len, size: 3'd2, burst: 2'b01};
    slv_req.aw_valid <= 1'b1;
    @(posedge clk_i);
    while (!slv_resp_o.aw_ready) begin
      if (slv_resp_o.b_valid) abort_run("B response appeared before the write address");
      else @(posedge clk_i);
    end
    slv_req.aw_valid <= 1'b0;
    beat = 0;
    while (beat <= int'(len)) begin
      r = next_random();
      if (r[1:0] == 2'b00) begin  // idle gap before this beat
        slv_req.w_valid <= 1'b0;
        @(posedge clk_i);
      end
      slv_req.w_valid <= 1'b1;
      slv_req.w       <= '{data: next_random(), strb: '1, last: (beat == int'(len))};
      @(posedge clk_i);
      while (!slv_resp_o.w_ready) begin
        if (slv_resp_o.b_valid) abort_run("B response appeared before the last write beat");
        else @(posedge clk_i);
      end
      beat++;
    end
    slv_req.w_valid <= 1'b0;
    slv_req.b_ready <= random_ready();
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      if (slv_resp_o.b_valid && slv_req.b_ready) begin
        check_b("slv_resp_o.b", slv_resp_o.b, exp_b);
        done = 1'b1;
      end
      slv_req.b_ready <= done ? 1'b0 : random_ready();
    end
  endtask

  task automatic run_read(input remap_pkg::id_t txn_id, input remap_pkg::slv_addr_t addr,
                          input remap_pkg::len_t len);
    remap_pkg::remap_xlate_t exp;
    remap_pkg::r_chan_t      exp_r;
    int                      beat;
    logic                    done;
    exp = model_xlate(addr);
    slv_req.ar       <= '{id: txn_id, addr: addr, len: len, size: 3'd2, burst: 2'b01};
    slv_req.ar_valid <= 1'b1;
    @(posedge clk_i);
    while (!slv_resp_o.ar_ready) begin
      if (slv_resp_o.r_valid) abort_run("R beat appeared before the read address was accepted");
      else @(posedge clk_i);
    end
    slv_req.ar_valid <= 1'b0;
    slv_req.r_ready  <= random_ready();
    beat = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      if (slv_resp_o.r_valid && slv_req.r_ready) begin
        exp_r.id   = txn_id;
        exp_r.data = exp.err ? '0 : exp.addr[`REMAP_DATA_W-1:0] + beat; // master memory pattern
        exp_r.resp = exp.err ? remap_pkg::RESP_DECERR : remap_pkg::RESP_OKAY;
        exp_r.last = (beat == int'(len));
        check_r("slv_resp_o.r", slv_resp_o.r, exp_r);
        done = exp_r.last;
        beat++;
      end
      slv_req.r_ready <= done ? 1'b0 : random_ready();
    end
  endtask

  // master memory model, one write and one read at a time
  always @(posedge clk_i) begin
    if (reset_i) begin
      mst_resp    <= '0;
      rsp_wr_busy <= 1'b0;
      rsp_b_pend  <= 1'b0;
      rsp_rd_busy <= 1'b0;
    end else begin
      rsp_seed = lcg_step(rsp_seed);
      if (!rsp_wr_busy) begin
        if (mst_req_o.aw_valid && mst_resp.aw_ready) begin
          mst_resp.aw_ready <= 1'b0;
          mst_resp.b.id     <= mst_req_o.aw.id;
          rsp_wr_busy       <= 1'b1;
        end else begin
          mst_resp.aw_ready <= rsp_seed[31:30] != 2'b00;
        end
      end else if (!rsp_b_pend) begin
        if (mst_req_o.w_valid && mst_resp.w_ready && mst_req_o.w.last) begin
          mst_resp.w_ready <= 1'b0;
          mst_resp.b_valid <= 1'b1;
          mst_resp.b.resp  <= remap_pkg::RESP_OKAY;
          rsp_b_pend       <= 1'b1;
        end else begin
          mst_resp.w_ready <= rsp_seed[29:28] != 2'b00;
        end
      end else if (mst_resp.b_valid && mst_req_o.b_ready) begin
        mst_resp.b_valid <= 1'b0;
        rsp_b_pend       <= 1'b0;
        rsp_wr_busy      <= 1'b0;
      end
      if (!rsp_rd_busy) begin
        if (mst_req_o.ar_valid && mst_resp.ar_ready) begin
          mst_resp.ar_ready <= 1'b0;
          mst_resp.r_valid  <= 1'b1;
          mst_resp.r        <= '{id: mst_req_o.ar.id, data: mst_req_o.ar.addr[31:0],
                                 resp: remap_pkg::RESP_OKAY, last: (mst_req_o.ar.len == 8'd0)};
          rsp_rd_addr <= mst_req_o.ar.addr;
          rsp_rd_len  <= mst_req_o.ar.len;
          rsp_rd_beat <= '0;
          rsp_rd_busy <= 1'b1;
        end else begin
          mst_resp.ar_ready <= rsp_seed[27:26] != 2'b00;
        end
      end else if (mst_resp.r_valid && mst_req_o.r_ready) begin
        if (mst_resp.r.last) begin
          mst_resp.r_valid <= 1'b0;
          rsp_rd_busy      <= 1'b0;
        end else begin
          mst_resp.r.data <= rsp_rd_addr[31:0] + rsp_rd_beat + 32'd1;
          mst_resp.r.last <= (rsp_rd_beat + 8'd1 == rsp_rd_len);
          rsp_rd_beat     <= rsp_rd_beat + 8'd1;
        end
      end
    end
  end

  // master AW/AR must carry the translated address, rejected requests never appear
  always @(posedge clk_i) begin
    if (!reset_i && mst_req_o.aw_valid) begin
      mon_aw = model_xlate(slv_req.aw.addr);
      exp_aw = '{id: slv_req.aw.id, addr: mon_aw.addr, len: slv_req.aw.len,
                 size: slv_req.aw.size, burst: slv_req.aw.burst};
      if (mon_aw.err) begin
        abort_run("a write to a rejected address reached the master AW channel");
      end else begin
        check_mst_addr("mst_req_o.aw.addr", mst_req_o.aw.addr, mon_aw.addr);
        check_aw_chan("mst_req_o.aw", mst_req_o.aw, exp_aw);
      end
    end
    // write data of a forwarded write passes unchanged
    if (!reset_i && mst_req_o.w_valid) begin
      mon_w = model_xlate(slv_req.aw.addr);
      if (mon_w.err) begin
        abort_run("write data of a rejected write reached the master W channel");
      end else begin
        check_w("mst_req_o.w", mst_req_o.w, slv_req.w);
      end
    end
    if (!reset_i && mst_req_o.ar_valid) begin
      mon_ar = model_xlate(slv_req.ar.addr);
      exp_ar = '{id: slv_req.ar.id, addr: mon_ar.addr, len: slv_req.ar.len,
                 size: slv_req.ar.size, burst: slv_req.ar.burst};
      if (mon_ar.err) begin
        abort_run("a read from a rejected address reached the master AR channel");
      end else begin
        check_mst_addr("mst_req_o.ar.addr", mst_req_o.ar.addr, mon_ar.addr);
        check_ar_chan("mst_req_o.ar", mst_req_o.ar, exp_ar);
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run("timeout, the transactions did not finish within the cycle limit");
    end
  end

  initial begin
    logic [31:0] r;
    reset_i = 1'b1;
    build_rules();
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    for (int n = 0; n < NUM_TXN; n++) begin
      r = next_random();
      if (r[0]) run_read(r[7:4], pick_addr(), {5'd0, r[10:8]});
      else run_write(r[7:4], pick_addr(), {5'd0, r[10:8]});
    end
    @(posedge clk_i);
    $display("TEST OK");
    $finish;
  end

endmodule

//--- src/axi_addr_remap.sv
// ##########################################################
// AXI4 address remapper top, one slave port to one master
// port, rules_i is a static table with first match priority
// ##########################################################
`timescale 1ns/1ps
`include "remap_cfg.svh"

module axi_addr_remap (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  remap_pkg::remap_rule_t rules_i [`REMAP_NUM_RULES],
  input  remap_pkg::slv_req_t    slv_req_i,
  output remap_pkg::resp_t       slv_resp_o,
  output remap_pkg::mst_req_t    mst_req_o,
  input  remap_pkg::resp_t       mst_resp_i
);

  remap_pkg::slv_addr_t    aw_addr, ar_addr;
  remap_pkg::remap_match_t aw_match, ar_match;
  remap_pkg::remap_xlate_t aw_xlate, ar_xlate;

  remap_pkg::slv_req_t     conn_req;  // slave request after steering
  remap_pkg::resp_t        conn_resp; // master response seen by the steers

  // write steer outputs
  logic               wr_aw_valid, wr_w_valid, wr_b_ready;
  logic               wr_aw_ready, wr_w_ready, wr_b_valid;
  remap_pkg::b_chan_t wr_b;

  // read steer outputs
  logic               rd_ar_valid, rd_r_ready;
  logic               rd_ar_ready, rd_r_valid;
  remap_pkg::r_chan_t rd_r;

  remap_rule_decode i_aw_decode (
    .addr_i  ( aw_addr  ),
    .rules_i ( rules_i  ),
    .match_o ( aw_match )
  );

  remap_rule_decode i_ar_decode (
    .addr_i  ( ar_addr  ),
    .rules_i ( rules_i  ),
    .match_o ( ar_match )
  );

  remap_addr_xlate i_aw_xlate (
    .addr_i  ( aw_addr  ),
    .match_i ( aw_match ),
    .xlate_o ( aw_xlate )
  );

  remap_addr_xlate i_ar_xlate (
    .addr_i  ( ar_addr  ),
    .match_i ( ar_match ),
    .xlate_o ( ar_xlate )
  );

  // payload from the slave port, handshakes from the steers
  always_comb begin
    conn_req          = slv_req_i;
    conn_req.aw_valid = wr_aw_valid;
    conn_req.w_valid  = wr_w_valid;
    conn_req.b_ready  = wr_b_ready;
    conn_req.ar_valid = rd_ar_valid;
    conn_req.r_ready  = rd_r_ready;
  end

  axi_modify_address i_axi_modify_address (
    .slv_req_i     ( conn_req       ),
    .slv_resp_o    ( conn_resp      ),
    .slv_aw_addr_o ( aw_addr        ),
    .slv_ar_addr_o ( ar_addr        ),
    .mst_req_o     ( mst_req_o      ),
    .mst_resp_i    ( mst_resp_i     ),
    .mst_aw_addr_i ( aw_xlate.addr  ),
    .mst_ar_addr_i ( ar_xlate.addr  )
  );

  remap_write_steer i_write_steer (
    .clk_i      ( clk_i              ),
    .reset_i    ( reset_i            ),
    .aw_valid_i ( slv_req_i.aw_valid ),
    .aw_err_i   ( aw_xlate.err       ),
    .aw_id_i    ( slv_req_i.aw.id    ),
    .w_valid_i  ( slv_req_i.w_valid  ),
    .w_last_i   ( slv_req_i.w.last   ),
    .b_ready_i  ( slv_req_i.b_ready  ),
    .aw_ready_o ( wr_aw_ready        ),
    .w_ready_o  ( wr_w_ready         ),
    .b_o        ( wr_b               ),
    .b_valid_o  ( wr_b_valid         ),
    .aw_valid_o ( wr_aw_valid        ),
    .w_valid_o  ( wr_w_valid         ),
    .b_ready_o  ( wr_b_ready         ),
    .aw_ready_i ( conn_resp.aw_ready ),
    .w_ready_i  ( conn_resp.w_ready  ),
    .b_i        ( conn_resp.b        ),
    .b_valid_i  ( conn_resp.b_valid  )
  );

  remap_read_steer i_read_steer (
    .clk_i      ( clk_i              ),
    .reset_i    ( reset_i            ),
    .ar_valid_i ( slv_req_i.ar_valid ),
    .ar_err_i   ( ar_xlate.err       ),
    .ar_id_i    ( slv_req_i.ar.id    ),
    .ar_len_i   ( slv_req_i.ar.len   ),
    .r_ready_i  ( slv_req_i.r_ready  ),
    .ar_ready_o ( rd_ar_ready        ),
    .r_o        ( rd_r               ),
    .r_valid_o  ( rd_r_valid         ),
    .ar_valid_o ( rd_ar_valid        ),
    .r_ready_o  ( rd_r_ready         ),
    .ar_ready_i ( conn_resp.ar_ready ),
    .r_i        ( conn_resp.r        ),
    .r_valid_i  ( conn_resp.r_valid  )
  );

  assign slv_resp_o = '{
    aw_ready: wr_aw_ready,
    w_ready:  wr_w_ready,
    b:        wr_b,
    b_valid:  wr_b_valid,
    ar_ready: rd_ar_ready,
    r:        rd_r,
    r_valid:  rd_r_valid
  };

endmodule

//--- src/remap_read_steer.sv
// ##########################################################
// read direction FSM, forwards a legal read to the master
// or produces len+1 DECERR beats for a rejected one
// ##########################################################
`timescale 1ns/1ps

module remap_read_steer (
  input  logic                clk_i,
  input  logic                reset_i,
  // slave side
  input  logic                ar_valid_i,
  input  logic                ar_err_i,
  input  remap_pkg::id_t      ar_id_i,
  input  remap_pkg::len_t     ar_len_i,
  input  logic                r_ready_i,
  output logic                ar_ready_o,
  output remap_pkg::r_chan_t  r_o,
  output logic                r_valid_o,
  // master side
  output logic                ar_valid_o,
  output logic                r_ready_o,
  input  logic                ar_ready_i,
  input  remap_pkg::r_chan_t  r_i,
  input  logic                r_valid_i
);

  remap_pkg::steer_state_e state_q, state_d;
  remap_pkg::len_t         beat_cnt_q, beat_cnt_d;
  remap_pkg::id_t          err_id_q;
  remap_pkg::len_t         err_len_q;
  logic                    err_last;

  assign err_last = (beat_cnt_q == err_len_q);

  always_comb begin
    state_d    = state_q;
    beat_cnt_d = beat_cnt_q;
    ar_ready_o = 1'b0;
    ar_valid_o = 1'b0;
    r_o        = '0;
    r_valid_o  = 1'b0;
    r_ready_o  = 1'b0;
    case (state_q)
      remap_pkg::STEER_IDLE: begin
        if (ar_err_i) begin
          ar_ready_o = ar_valid_i;
          if (ar_valid_i) begin
            beat_cnt_d = '0;
            state_d    = remap_pkg::STEER_ERR_RESP;
          end
        end else begin
          ar_valid_o = ar_valid_i;
          ar_ready_o = ar_valid_i & ar_ready_i;
          if (ar_valid_i && ar_ready_i) begin
            state_d = remap_pkg::STEER_FWD;
          end
        end
      end
      remap_pkg::STEER_FWD: begin
        r_o       = r_i;
        r_valid_o = r_valid_i;
        r_ready_o = r_ready_i;
        if (r_valid_i && r_ready_i && r_i.last) begin
          state_d = remap_pkg::STEER_IDLE;
        end
      end
      remap_pkg::STEER_ERR_RESP: begin
        r_valid_o = 1'b1;
        r_o.id    = err_id_q;
        r_o.resp  = remap_pkg::RESP_DECERR; // data stays zero
        r_o.last  = err_last;
        if (r_ready_i) begin
          if (err_last) begin
            state_d = remap_pkg::STEER_IDLE;
          end else begin
            beat_cnt_d = beat_cnt_q + 8'd1;
          end
        end
      end
      default: state_d = remap_pkg::STEER_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= remap_pkg::STEER_IDLE;
      beat_cnt_q <= '0;
    end else begin
      state_q    <= state_d;
      beat_cnt_q <= beat_cnt_d;
    end
  end

  // id and burst length of the rejected read
  always_ff @(posedge clk_i) begin
    if (state_q == remap_pkg::STEER_IDLE && ar_valid_i && ar_err_i) begin
      err_id_q  <= ar_id_i;
      err_len_q <= ar_len_i;
    end
  end

endmodule

//--- src/remap_write_steer.sv
// ##########################################################
// write direction FSM, forwards a legal write to the master
// or swallows a rejected one and answers it with DECERR
// ##########################################################
`timescale 1ns/1ps

module remap_write_steer (
  input  logic                clk_i,
  input  logic                reset_i,
  // slave side
  input  logic                aw_valid_i,
  input  logic                aw_err_i,
  input  remap_pkg::id_t      aw_id_i,
  input  logic                w_valid_i,
  input  logic                w_last_i,
  input  logic                b_ready_i,
  output logic                aw_ready_o,
  output logic                w_ready_o,
  output remap_pkg::b_chan_t  b_o,
  output logic                b_valid_o,
  // master side
  output logic                aw_valid_o,
  output logic                w_valid_o,
  output logic                b_ready_o,
  input  logic                aw_ready_i,
  input  logic                w_ready_i,
  input  remap_pkg::b_chan_t  b_i,
  input  logic                b_valid_i
);

  remap_pkg::steer_state_e state_q, state_d;
  remap_pkg::id_t          err_id_q; // id of the rejected write

  always_comb begin
    state_d    = state_q;
    aw_ready_o = 1'b0;
    aw_valid_o = 1'b0;
    w_ready_o  = 1'b0;
    w_valid_o  = 1'b0;
    b_o        = '0;
    b_valid_o  = 1'b0;
    b_ready_o  = 1'b0;
    case (state_q)
      remap_pkg::STEER_IDLE: begin
        if (aw_err_i) begin
          aw_ready_o = aw_valid_i; // accept at once, master never sees it
          if (aw_valid_i) begin
            state_d = remap_pkg::STEER_ERR_DATA;
          end
        end else begin
          aw_valid_o = aw_valid_i;
          aw_ready_o = aw_valid_i & aw_ready_i;
          if (aw_valid_i && aw_ready_i) begin
            state_d = remap_pkg::STEER_FWD;
          end
        end
      end
      remap_pkg::STEER_FWD: begin
        w_valid_o = w_valid_i;
        w_ready_o = w_ready_i;
        b_o       = b_i;
        b_valid_o = b_valid_i;
        b_ready_o = b_ready_i;
        if (b_valid_i && b_ready_i) begin
          state_d = remap_pkg::STEER_IDLE;
        end
      end
      remap_pkg::STEER_ERR_DATA: begin
        w_ready_o = 1'b1; // data is dropped
        if (w_valid_i && w_last_i) begin
          state_d = remap_pkg::STEER_ERR_RESP;
        end
      end
      remap_pkg::STEER_ERR_RESP: begin
        b_valid_o = 1'b1;
        b_o.id    = err_id_q;
        b_o.resp  = remap_pkg::RESP_DECERR;
        if (b_ready_i) begin
          state_d = remap_pkg::STEER_IDLE;
        end
      end
      default: state_d = remap_pkg::STEER_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= remap_pkg::STEER_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == remap_pkg::STEER_IDLE && aw_valid_i && aw_err_i) begin
      err_id_q <= aw_id_i;
    end
  end

endmodule

//--- src/axi_modify_address.sv
// ##########################################################
// AXI connector that swaps in new AW/AR addresses
// everything else passes straight through in both directions
// ##########################################################
`timescale 1ns/1ps

module axi_modify_address (
  // slave port
  input  remap_pkg::slv_req_t  slv_req_i,
  output remap_pkg::resp_t     slv_resp_o,
  output remap_pkg::slv_addr_t slv_aw_addr_o,
  output remap_pkg::slv_addr_t slv_ar_addr_o,
  // master port
  output remap_pkg::mst_req_t  mst_req_o,
  input  remap_pkg::resp_t     mst_resp_i,
  input  remap_pkg::mst_addr_t mst_aw_addr_i,
  input  remap_pkg::mst_addr_t mst_ar_addr_i
);

  // original addresses go out for translation
  assign slv_aw_addr_o = slv_req_i.aw.addr;
  assign slv_ar_addr_o = slv_req_i.ar.addr;

  assign mst_req_o = '{
    aw: '{
      id:    slv_req_i.aw.id,
      addr:  mst_aw_addr_i,   // translated
      len:   slv_req_i.aw.len,
      size:  slv_req_i.aw.size,
      burst: slv_req_i.aw.burst
    },
    aw_valid: slv_req_i.aw_valid,
    w:        slv_req_i.w,
    w_valid:  slv_req_i.w_valid,
    b_ready:  slv_req_i.b_ready,
    ar: '{
      id:    slv_req_i.ar.id,
      addr:  mst_ar_addr_i,   // translated
      len:   slv_req_i.ar.len,
      size:  slv_req_i.ar.size,
      burst: slv_req_i.ar.burst
    },
    ar_valid: slv_req_i.ar_valid,
    r_ready:  slv_req_i.r_ready
  };

  // responses carry no address
  assign slv_resp_o = mst_resp_i;

endmodule

//--- src/remap_addr_xlate.sv
// ##########################################################
// applies a matched rule: offset, identity or error flag
// ##########################################################
`timescale 1ns/1ps

module remap_addr_xlate (
  input  remap_pkg::slv_addr_t    addr_i,
  input  remap_pkg::remap_match_t match_i,
  output remap_pkg::remap_xlate_t xlate_o
);

  remap_pkg::slv_addr_t win_offset; // distance into the matched window

  // never negative on a hit, since start_addr <= addr_i
  assign win_offset = addr_i - match_i.start_addr;

  always_comb begin
    xlate_o = '0;
    if (match_i.hit) begin
      case (match_i.op)
        remap_pkg::REMAP_OFFSET: begin
          xlate_o.addr = match_i.target_addr + remap_pkg::mst_addr_t'(win_offset);
        end
        remap_pkg::REMAP_IDENTITY: begin
          xlate_o.addr = remap_pkg::mst_addr_t'(addr_i); // zero-extend
        end
        default: begin
          xlate_o.err = 1'b1; // deny rule, address stays zero
        end
      endcase
    end else begin
      xlate_o.err = 1'b1;   // no rule covers the address
    end
  end

endmodule

//--- src/remap_rule_decode.sv
// ##########################################################
// first-match lookup of an address in the remap rule table
// ##########################################################
`timescale 1ns/1ps
`include "remap_cfg.svh"

module remap_rule_decode (
  input  remap_pkg::slv_addr_t    addr_i,
  input  remap_pkg::remap_rule_t  rules_i [`REMAP_NUM_RULES],
  output remap_pkg::remap_match_t match_o
);

  logic [`REMAP_NUM_RULES-1:0] rule_hit;

  // window compare for all rules at once
  always_comb begin
    for (int i = 0; i < `REMAP_NUM_RULES; i++) begin
      rule_hit[i] = (addr_i >= rules_i[i].start_addr) &&
                    (addr_i <  rules_i[i].end_addr);
    end
  end

  // walk from the top so that the lowest index is written last
  always_comb begin
    match_o = '0;
    for (int i = `REMAP_NUM_RULES - 1; i >= 0; i--) begin
      if (rule_hit[i]) begin
        match_o.hit         = 1'b1;
        match_o.op          = rules_i[i].op;
        match_o.start_addr  = rules_i[i].start_addr;
        match_o.target_addr = rules_i[i].target_addr;
      end
    end
  end

endmodule

//--- src/remap_pkg.sv
// ##########################################################
// AXI channel, request/response and remap rule types
// ##########################################################
`include "remap_cfg.svh"

package remap_pkg;

  typedef logic [`REMAP_SLV_ADDR_W-1:0] slv_addr_t;
  typedef logic [`REMAP_MST_ADDR_W-1:0] mst_addr_t;
  typedef logic [`REMAP_ID_W-1:0]       id_t;
  typedef logic [`REMAP_DATA_W-1:0]     data_t;
  typedef logic [`REMAP_DATA_W/8-1:0]   strb_t;
  typedef logic [7:0]                   len_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic [1:0] {
    REMAP_OFFSET,   // relocate into target window
    REMAP_IDENTITY, // keep address, zero-extended
    REMAP_DENY      // answer with DECERR
  } remap_op_e;

  typedef enum logic [1:0] {
    STEER_IDLE,
    STEER_FWD,
    STEER_ERR_DATA,
    STEER_ERR_RESP
  } steer_state_e;

  // address channels, same layout for AW and AR
  typedef struct packed {
    id_t        id;
    slv_addr_t  addr;
    len_t       len;
    logic [2:0] size;
    logic [1:0] burst;
  } slv_aw_chan_t;

  typedef struct packed {
    id_t        id;
    mst_addr_t  addr;
    len_t       len;
    logic [2:0] size;
    logic [1:0] burst;
  } mst_aw_chan_t;

  typedef struct packed {
    id_t        id;
    slv_addr_t  addr;
    len_t       len;
    logic [2:0] size;
    logic [1:0] burst;
  } slv_ar_chan_t;

  typedef struct packed {
    id_t        id;
    mst_addr_t  addr;
    len_t       len;
    logic [2:0] size;
    logic [1:0] burst;
  } mst_ar_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t       id;
    axi_resp_e resp;
  } b_chan_t;

  typedef struct packed {
    id_t       id;
    data_t     data;
    axi_resp_e resp;
    logic      last;
  } r_chan_t;

  typedef struct packed {
    slv_aw_chan_t aw;
    logic         aw_valid;
    w_chan_t      w;
    logic         w_valid;
    logic         b_ready;
    slv_ar_chan_t ar;
    logic         ar_valid;
    logic         r_ready;
  } slv_req_t;

  typedef struct packed {
    mst_aw_chan_t aw;
    logic         aw_valid;
    w_chan_t      w;
    logic         w_valid;
    logic         b_ready;
    mst_ar_chan_t ar;
    logic         ar_valid;
    logic         r_ready;
  } mst_req_t;

  // one response type serves both ports
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } resp_t;

  typedef struct packed {
    remap_op_e op;
    slv_addr_t start_addr;  // inclusive
    slv_addr_t end_addr;    // exclusive
    mst_addr_t target_addr;
  } remap_rule_t;

  typedef struct packed {
    logic      hit;
    remap_op_e op;
    slv_addr_t start_addr;
    mst_addr_t target_addr;
  } remap_match_t;

  typedef struct packed {
    mst_addr_t addr;
    logic      err;  // deny or miss
  } remap_xlate_t;

endpackage

//--- include/remap_cfg.svh
// ##########################################################
// widths and rule table size of the AXI address remapper
// included by the package and by modules sized by the table
// ##########################################################
`ifndef REMAP_CFG_SVH
`define REMAP_CFG_SVH

`define REMAP_SLV_ADDR_W 32 // slave port address
`define REMAP_MST_ADDR_W 40 // master port address, wider than the slave side

`define REMAP_ID_W       4
`define REMAP_DATA_W     32

// rule entries checked in parallel, index 0 has highest priority
`define REMAP_NUM_RULES  4

`endif
